/* common/riscv_pkg.sv */
/*
 * Shared types and constants of the five-stage RV32I pipeline.
 * Every stage module imports this package in its header.
 */
`default_nettype none

package riscv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [29:0] word_addr_t;   // Byte address without bits 1:0
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;

    localparam alu_op_t ALU_NONE = 4'd0;  // Result is 0
    localparam alu_op_t ALU_ADD  = 4'd1;
    localparam alu_op_t ALU_SUB  = 4'd2;
    localparam alu_op_t ALU_AND  = 4'd3;
    localparam alu_op_t ALU_OR   = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SLL  = 4'd6;
    localparam alu_op_t ALU_SRL  = 4'd7;
    localparam alu_op_t ALU_SRA  = 4'd8;
    localparam alu_op_t ALU_SLT  = 4'd9;

    // Operand source in execute
    localparam fwd_sel_t FWD_REG = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam word_t NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

    typedef struct packed {
        logic      alu_src;     // Operand b from imm
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        alu_op_t   alu_op;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t rd;
        word_t     alu_result;  // Also the data address
        word_t     store_data;
    } ex_mem_t;

endpackage

`default_nettype wire

/* src/fetch_stage.sv */
/*
 * Fetch stage. Owns the fetch program counter and the instruction
 * register that feeds decode, with branch flush and stall hold.
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_stage
    import riscv_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       hold,           // Load-use bubble
    input  logic       stall,
    input  logic       branch_taken,
    input  word_t      branch_target,
    output word_addr_t imem_addr,
    input  word_t      imem_rdata,
    output word_t      pc,             // Address of instr
    output word_t      instr
);
    word_t fetch_pc;

    assign imem_addr = fetch_pc[31:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_pc <= '0;
            pc       <= '0;
            instr    <= NOP_INSTR;
        end else if (stall || hold) begin
            fetch_pc <= fetch_pc;   // Freeze
        end else if (branch_taken) begin
            fetch_pc <= branch_target;
            pc       <= fetch_pc;
            instr    <= NOP_INSTR;  // Flush the slot behind the branch
        end else begin
            fetch_pc <= fetch_pc + 32'd4;
            pc       <= fetch_pc;
            instr    <= imem_rdata;
        end
    end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
/*
 * Decode stage. Builds control bits, immediates and the ALU operation,
 * resolves beq and bne against the register file values, and loads
 * the decode-to-execute register.
 */
`timescale 1ns/100ps
`default_nettype none

module decode_stage
    import riscv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    input  logic      load_stall,
    input  word_t     pc,
    input  word_t     instr,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output logic      uses_rs2,
    output logic      branch_taken,
    output word_t     branch_target,
    output id_ex_t    id_ex
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_op;
    logic       is_op_imm;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       equal;
    word_t      imm;
    word_t      imm_b;
    alu_op_t    alu_op;
    id_ex_t     id_ex_next;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_load   = (opcode == OPC_LOAD);
    assign is_store  = (opcode == OPC_STORE);
    assign is_branch = (opcode == OPC_BRANCH);
    assign uses_rs2  = is_op | is_store | is_branch;

    always_comb begin
        if (is_store)
            imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        else if (is_op_imm && (funct3 == 3'b001 || funct3 == 3'b101))
            imm = {27'd0, instr[24:20]};  // Shift amount
        else
            imm = {{20{instr[31]}}, instr[31:20]};
    end

    always_comb begin
        alu_op = ALU_NONE;
        if (is_op || is_op_imm) begin
            case (funct3)
                3'b000:  alu_op = (is_op && instr[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = is_op_imm ? ALU_SLL : ALU_NONE;
                3'b010:  alu_op = ALU_SLT;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = !is_op_imm ? ALU_NONE : (instr[30] ? ALU_SRA : ALU_SRL);
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end else if (is_load || is_store) begin
            alu_op = ALU_ADD;   // Address calc
        end
    end

    // Branch resolve, no forwarding into the compare
    assign equal         = (rs1_data == rs2_data);
    assign imm_b         = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign branch_target = pc + imm_b;
    assign branch_taken  = is_branch & (((funct3 == 3'b000) & equal) |
                                        ((funct3 == 3'b001) & ~equal));

    always_comb begin
        id_ex_next.alu_src   = is_op_imm | is_load | is_store;
        id_ex_next.mem_read  = is_load;
        id_ex_next.mem_write = is_store;
        id_ex_next.reg_write = is_op | is_op_imm | is_load;
        id_ex_next.alu_op    = alu_op;
        id_ex_next.rs1_data  = rs1_data;
        id_ex_next.rs2_data  = rs2_data;
        id_ex_next.imm       = imm;
        id_ex_next.rs1       = rs1;
        id_ex_next.rs2       = rs2;
        id_ex_next.rd        = instr[11:7];
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            id_ex <= '0;
        else if (!stall)
            id_ex <= load_stall ? '0 : id_ex_next;  // Zero-control bubble
    end

endmodule

`default_nettype wire

/* src/reg_file.sv */
/*
 * Integer register file, 32 words, two read ports and one write port.
 * A write in the same cycle is visible on the read ports.
 */
`timescale 1ns/100ps
`default_nettype none

module reg_file
    import riscv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wb_we,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data
);
    word_t regs [32];
    logic  wr_en;

    assign wr_en = wb_we && (wb_rd != '0);  // x0 stays 0

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_data = (wr_en && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (wr_en && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
/*
 * Hazard logic. Detects a load followed by a dependent instruction
 * and picks the forwarding source for both execute operands.
 */
`timescale 1ns/100ps
`default_nettype none

module hazard_unit
    import riscv_pkg::*;
(
    input  reg_addr_t rs1,        // Decode operands
    input  reg_addr_t rs2,
    input  logic      uses_rs2,
    input  id_ex_t    id_ex,
    input  ex_mem_t   ex_mem,
    input  logic      wb_we,
    input  reg_addr_t wb_rd,
    output fwd_sel_t  fwd_a,
    output fwd_sel_t  fwd_b,
    output logic      load_stall
);
    // Memory stage wins, it holds the younger result
    function automatic fwd_sel_t fwd_select(reg_addr_t src, logic mem_we, reg_addr_t mem_rd,
                                            logic wb_en, reg_addr_t wb_dst);
        if (mem_we && mem_rd != '0 && mem_rd == src)
            return FWD_MEM;
        else if (wb_en && wb_dst != '0 && wb_dst == src)
            return FWD_WB;
        return FWD_REG;
    endfunction

    assign fwd_a = fwd_select(id_ex.rs1, ex_mem.reg_write, ex_mem.rd, wb_we, wb_rd);
    assign fwd_b = fwd_select(id_ex.rs2, ex_mem.reg_write, ex_mem.rd, wb_we, wb_rd);

    assign load_stall = id_ex.mem_read && (id_ex.rd != '0) &&
                        ((id_ex.rd == rs1) || (uses_rs2 && id_ex.rd == rs2));

endmodule

`default_nettype wire

/* src/execute_stage.sv */
/*
 * Execute stage. Forwards operands from the memory and writeback
 * stages, runs the ALU and loads the execute-to-memory register.
 */
`timescale 1ns/100ps
`default_nettype none

module execute_stage
    import riscv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  id_ex_t   id_ex,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  word_t    wb_data,
    output ex_mem_t  ex_mem
);
    word_t   rs1_fwd;
    word_t   rs2_fwd;
    word_t   op_b;
    word_t   result;
    ex_mem_t ex_mem_next;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign rs1_fwd = fwd_mux(fwd_a, id_ex.rs1_data, ex_mem.alu_result, wb_data);
    assign rs2_fwd = fwd_mux(fwd_b, id_ex.rs2_data, ex_mem.alu_result, wb_data);
    assign op_b    = id_ex.alu_src ? id_ex.imm : rs2_fwd;  // Imm never overridden

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: result = rs1_fwd + op_b;
            ALU_SUB: result = rs1_fwd - op_b;
            ALU_AND: result = rs1_fwd & op_b;
            ALU_OR:  result = rs1_fwd | op_b;
            ALU_XOR: result = rs1_fwd ^ op_b;
            ALU_SLL: result = rs1_fwd << op_b[4:0];
            ALU_SRL: result = rs1_fwd >> op_b[4:0];
            ALU_SRA: result = $signed(rs1_fwd) >>> op_b[4:0];
            ALU_SLT: result = {31'd0, $signed(rs1_fwd) < $signed(op_b)};
            default: result = '0;
        endcase
    end

    always_comb begin
        ex_mem_next.mem_read   = id_ex.mem_read;
        ex_mem_next.mem_write  = id_ex.mem_write;
        ex_mem_next.reg_write  = id_ex.reg_write;
        ex_mem_next.rd         = id_ex.rd;
        ex_mem_next.alu_result = result;
        ex_mem_next.store_data = rs2_fwd;   // Forwarded store data
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            ex_mem <= '0;
        else if (!stall)
            ex_mem <= ex_mem_next;
    end

endmodule

`default_nettype wire

/* src/result_stage.sv */
/*
 * Memory and writeback. Drives the data port straight from the
 * execute-to-memory register, then registers the result for writeback.
 */
`timescale 1ns/100ps
`default_nettype none

module result_stage
    import riscv_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ex_mem_t    ex_mem,
    output logic       dmem_ren,
    output logic       dmem_wen,
    output word_addr_t dmem_addr,
    output word_t      dmem_wdata,
    input  word_t      dmem_rdata,
    input  logic       dmem_stall,
    output logic       wb_we,
    output reg_addr_t  wb_rd,
    output word_t      wb_data
);
    logic  wb_load;
    word_t wb_alu;
    word_t wb_mem;

    assign dmem_ren   = ex_mem.mem_read;
    assign dmem_wen   = ex_mem.mem_write;
    assign dmem_addr  = ex_mem.alu_result[31:2];
    assign dmem_wdata = ex_mem.store_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_we   <= 1'b0;
            wb_load <= 1'b0;
        end else if (!dmem_stall) begin
            wb_we   <= ex_mem.reg_write;
            wb_load <= ex_mem.mem_read;
        end
    end

    // Payload, read data valid once stall drops
    always_ff @(posedge clk) begin
        if (!dmem_stall) begin
            wb_rd  <= ex_mem.rd;
            wb_alu <= ex_mem.alu_result;
            wb_mem <= dmem_rdata;
        end
    end

    assign wb_data = wb_load ? wb_mem : wb_alu;

endmodule

`default_nettype wire

/* src/riscv_core.sv */
/*
 * Five-stage RV32I core top. Connects fetch, decode, register file,
 * hazard logic, execute and memory/writeback to the two memory ports.
 */
`timescale 1ns/100ps
`default_nettype none

module riscv_core
    import riscv_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    output word_addr_t imem_addr,
    input  word_t      imem_rdata,
    output logic       dmem_ren,
    output logic       dmem_wen,
    output word_addr_t dmem_addr,
    output word_t      dmem_wdata,
    input  word_t      dmem_rdata,
    input  logic       dmem_stall
);
    word_t     pc;
    word_t     instr;
    logic      branch_taken;
    word_t     branch_target;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      uses_rs2;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    logic      load_stall;
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    fetch_stage fetch_stage_inst (
        .clk, .rst_n, .hold(load_stall), .stall(dmem_stall), .branch_taken,
        .branch_target, .imem_addr, .imem_rdata, .pc, .instr
    );

    decode_stage decode_stage_inst (
        .clk, .rst_n, .stall(dmem_stall), .load_stall, .pc, .instr, .rs1, .rs2,
        .rs1_data, .rs2_data, .uses_rs2, .branch_taken, .branch_target, .id_ex
    );

    reg_file reg_file_inst (
        .clk, .rst_n, .rs1, .rs2, .rs1_data, .rs2_data, .wb_we, .wb_rd, .wb_data
    );

    hazard_unit hazard_unit_inst (
        .rs1, .rs2, .uses_rs2, .id_ex, .ex_mem, .wb_we, .wb_rd, .fwd_a, .fwd_b, .load_stall
    );

    execute_stage execute_stage_inst (
        .clk, .rst_n, .stall(dmem_stall), .id_ex, .fwd_a, .fwd_b, .wb_data, .ex_mem
    );

    result_stage result_stage_inst (
        .clk, .rst_n, .ex_mem, .dmem_ren, .dmem_wen, .dmem_addr, .dmem_wdata,
        .dmem_rdata, .dmem_stall, .wb_we, .wb_rd, .wb_data
    );

endmodule

`default_nettype wire

/* sim/riscv_core_props.sv */
/*
 * Data port checks for the memory stage, bound into result_stage
 * from the testbench.
 */
`timescale 1ns/100ps
`default_nettype none

module riscv_core_props
    import riscv_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       dmem_ren,
    input logic       dmem_wen,
    input word_addr_t dmem_addr,
    input word_t      dmem_wdata,
    input logic       dmem_stall
);
    // Never a read and a write together
    assert property (@(posedge clk) disable iff (!rst_n) !(dmem_ren && dmem_wen))
        else $error("Data port raised read and write enables together");

    // Request is frozen until stall drops
    assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_ren || dmem_wen) && dmem_stall |=>
            $stable(dmem_ren) && $stable(dmem_wen) && $stable(dmem_addr) && $stable(dmem_wdata))
        else $error("Data port request changed while stall was high");

    assert property (@(posedge clk) !rst_n |=> !dmem_ren && !dmem_wen)
        else $error("Data port enable high during reset");

endmodule

`default_nettype wire

/* sim/riscv_core_tb.sv */
/*
 * Directed testbench for the pipeline core. Models instruction and data
 * memory, loads a small program per test, runs it to its end loop and
 * compares data memory words against values worked out from the ISA.
 */
`timescale 1ns/100ps
`default_nettype none

module riscv_core_tb
    import riscv_pkg::*;
();
    localparam int NUM_TESTS      = 5;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 200 * 2;  // Doubled for random stall

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic       dmem_stall = 1'b0;
    logic       stall_random = 1'b0;
    word_addr_t imem_addr;
    word_t      imem_rdata;
    logic       dmem_ren;
    logic       dmem_wen;
    word_addr_t dmem_addr;
    word_t      dmem_wdata;
    word_t      dmem_rdata;

    word_t imem [256];
    word_t dmem [64];
    word_t snapshot [64];
    word_t prog [$];
    word_t expect_q [$];
    int    errors = 0;
    int    checks = 0;
    int    cycle_count = 0;

    riscv_core riscv_core_inst (
        .clk, .rst_n, .imem_addr, .imem_rdata, .dmem_ren, .dmem_wen,
        .dmem_addr, .dmem_wdata, .dmem_rdata, .dmem_stall
    );

    bind result_stage riscv_core_props riscv_core_props_inst (
        .clk, .rst_n, .dmem_ren, .dmem_wen, .dmem_addr, .dmem_wdata, .dmem_stall
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    assign imem_rdata = imem[imem_addr[7:0]];
    // Valid only for an unstalled read
    assign dmem_rdata = (dmem_ren && !dmem_stall) ? dmem[dmem_addr[5:0]] : '0;

    function automatic word_t fill_word(int idx);
        return {16'hd0d0, 10'h000, idx[5:0]};
    endfunction

    // Refilled on every reset cycle
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 64; i++)
                dmem[i] <= fill_word(i);
        end else if (dmem_wen && !dmem_stall) begin
            dmem[dmem_addr[5:0]] <= dmem_wdata;
        end
    end

    always @(posedge clk) begin
        #1;
        dmem_stall = stall_random ? (($urandom % 3) == 0) : 1'b0;
    end

    // RV32I encodings
    function automatic word_t r_type(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic word_t i_type(int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP_IMM};
    endfunction

    function automatic word_t load_word(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], OPC_LOAD};
    endfunction

    function automatic word_t store_word(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t branch(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    task automatic pad(int n);
        repeat (n) prog.push_back(NOP_INSTR);
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Load program, reset, run until the end loop has been fetched a few times
    task automatic run_program(bit random_stall);
        int end_idx;
        int seen;
        end_idx = prog.size();
        prog.push_back(branch(0, 0, 0, 0));   // Self loop
        stall_random = random_stall;
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        for (int i = 0; i < 256; i++)
            imem[i] = (i < prog.size()) ? prog[i] : {4'h0, i[7:0], 20'h00013};
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        seen = 0;
        while (seen < 6) begin
            @(negedge clk);
            if (imem_addr == word_addr_t'(end_idx) && !dmem_stall)
                seen++;
        end
    endtask

    // Op writes x10, stored at once to the next result word
    task automatic alu_case(word_t instr, word_t expected);
        prog.push_back(instr);
        prog.push_back(store_word(10, 0, 4 * expect_q.size()));
        expect_q.push_back(expected);
    endtask

    task automatic alu_ops();
        word_t a;
        word_t b;
        word_t c;
        a = 32'd1234;
        b = -32'sd300;
        c = 32'h0000_05a5;
        prog.delete();
        expect_q.delete();
        prog.push_back(i_type(0, 1, 0, 1234));
        prog.push_back(i_type(0, 2, 0, -300));
        prog.push_back(i_type(0, 3, 0, 'h5a5));
        alu_case(r_type(0, 0, 10, 1, 2), a + b);
        alu_case(r_type(32, 0, 10, 1, 2), a - b);
        alu_case(r_type(0, 2, 10, 2, 1), {31'd0, $signed(b) < $signed(a)});
        alu_case(r_type(0, 2, 10, 1, 2), {31'd0, $signed(a) < $signed(b)});
        alu_case(r_type(0, 4, 10, 1, 3), a ^ c);
        alu_case(r_type(0, 6, 10, 1, 3), a | c);
        alu_case(r_type(0, 7, 10, 1, 3), a & c);
        alu_case(i_type(0, 10, 2, 77), b + 32'd77);
        alu_case(i_type(2, 10, 2, -5), {31'd0, $signed(b) < -32'sd5});
        alu_case(i_type(4, 10, 1, -1), a ^ 32'hffff_ffff);
        alu_case(i_type(6, 10, 1, 'h0f0), a | 32'h0000_00f0);
        alu_case(i_type(7, 10, 3, 'h0ff), c & 32'h0000_00ff);
        alu_case(i_type(1, 10, 1, 7), a << 7);
        alu_case(i_type(5, 10, 2, 4), b >> 4);
        alu_case(i_type(5, 10, 2, 'h404), $signed(b) >>> 4);   // srai
        run_program(1'b0);
        for (int i = 0; i < expect_q.size(); i++)
            check_word($sformatf("alu word %0d", i), expect_q[i], dmem[i]);
    endtask

    // Same chain at distance one, two and fully spaced
    task automatic forwarding_chain(bit random_stall);
        word_t sum;
        word_t dbl;
        word_t diff;
        string name;
        sum  = 32'd5 + 32'd9;
        dbl  = sum + sum;
        diff = 32'd9 - dbl;
        name = random_stall ? "forward_stall" : "forward";
        prog.delete();
        prog.push_back(i_type(0, 1, 0, 5));
        prog.push_back(i_type(0, 2, 0, 9));
        pad(3);
        prog.push_back(r_type(0, 0, 3, 1, 2));
        prog.push_back(r_type(0, 0, 4, 3, 3));     // Both operands from memory stage
        prog.push_back(r_type(32, 0, 5, 2, 4));
        prog.push_back(store_word(5, 0, 64));
        prog.push_back(store_word(4, 0, 68));      // Store data via register write-through
        prog.push_back(r_type(0, 0, 6, 1, 2));
        pad(1);
        prog.push_back(r_type(0, 0, 7, 6, 6));
        pad(1);
        prog.push_back(r_type(32, 0, 8, 2, 7));
        pad(1);
        prog.push_back(store_word(8, 0, 72));
        prog.push_back(r_type(0, 0, 9, 1, 2));
        pad(3);
        prog.push_back(r_type(0, 0, 11, 9, 9));
        pad(3);
        prog.push_back(r_type(32, 0, 12, 2, 11));
        pad(3);
        prog.push_back(store_word(12, 0, 76));
        prog.push_back(store_word(11, 0, 80));
        run_program(random_stall);
        check_word({name, " dist1 diff"}, diff, dmem[16]);
        check_word({name, " dist1 dbl"}, dbl, dmem[17]);
        check_word({name, " dist2 diff"}, diff, dmem[18]);
        check_word({name, " spaced diff"}, diff, dmem[19]);
        check_word({name, " spaced dbl"}, dbl, dmem[20]);
        for (int i = 0; i < 64; i++) begin
            if (random_stall)
                check_word($sformatf("%s word %0d", name, i), snapshot[i], dmem[i]);
            else
                snapshot[i] = dmem[i];
        end
    endtask

    task automatic load_use_bubble();
        word_t loaded;
        loaded = fill_word(40);
        prog.delete();
        prog.push_back(i_type(0, 1, 0, 7));
        pad(3);
        prog.push_back(load_word(2, 0, 160));
        prog.push_back(r_type(0, 0, 3, 2, 1));   // Bubble, then writeback forward
        prog.push_back(store_word(3, 0, 164));
        prog.push_back(load_word(4, 0, 160));
        prog.push_back(store_word(4, 0, 168));
        prog.push_back(load_word(5, 0, 160));
        prog.push_back(r_type(0, 0, 6, 1, 5));   // Loaded value on rs2
        prog.push_back(store_word(6, 0, 172));
        run_program(1'b0);
        check_word("load_use add", loaded + 32'd7, dmem[41]);
        check_word("load_use store", loaded, dmem[42]);
        check_word("load_use add rs2", loaded + 32'd7, dmem[43]);
    endtask

    task automatic branch_skips();
        logic [8:0] hit;
        hit = 9'b1_0010_1110;   // Words 49 50 51 53 56 get the marker
        prog.delete();
        prog.push_back(i_type(0, 1, 0, 5));
        prog.push_back(i_type(0, 2, 0, 5));
        prog.push_back(i_type(0, 3, 0, 6));
        prog.push_back(i_type(0, 9, 0, 'h7a));
        pad(3);
        prog.push_back(branch(0, 1, 2, 8));     // beq taken
        prog.push_back(store_word(9, 0, 192));  // Flushed slot
        prog.push_back(store_word(9, 0, 196));
        prog.push_back(branch(1, 1, 2, 8));     // bne not taken
        prog.push_back(store_word(9, 0, 200));
        prog.push_back(branch(0, 1, 3, 8));     // beq not taken
        prog.push_back(store_word(9, 0, 204));
        prog.push_back(branch(1, 1, 3, 8));     // bne taken
        prog.push_back(store_word(9, 0, 208));
        prog.push_back(store_word(9, 0, 212));
        prog.push_back(branch(0, 0, 0, 12));    // Skips two
        prog.push_back(store_word(9, 0, 216));
        prog.push_back(store_word(9, 0, 220));
        prog.push_back(store_word(9, 0, 224));
        run_program(1'b0);
        for (int k = 0; k < 9; k++)
            check_word($sformatf("branch word %0d", 48 + k),
                       hit[k] ? 32'h0000_007a : fill_word(48 + k), dmem[48 + k]);
    endtask

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: no program reached its end loop within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h8e40));
        alu_ops();
        forwarding_chain(1'b0);
        load_use_bubble();
        branch_skips();
        forwarding_chain(1'b1);   // Rerun under random data port stall
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
common/riscv_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/hazard_unit.sv
src/execute_stage.sv
src/result_stage.sv
src/riscv_core.sv
sim/riscv_core_props.sv
sim/riscv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the core and its testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module riscv_core_tb -f build.f || exit 1
out="$(./obj_dir/Vriscv_core_tb)"
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1
